/* bench/qla_stimulus.txt */
# op name addr_or_sel value expected, numbers in hex
# W write, F feedback by axis, R read, N wait value cycles, O output by select, L led count
R rst_status     00 0        0
R rst_led_duty   02 0        0
R rst_cmd3       31 0        0
O rst_amp_on     0  0        0
O rst_led        5  0        0
W cmd1_wr        11 00010064 0
W cmd2_wr        21 0200     0
W cmd3_wr        31 0300     0
W cmd4_wr        41 ffff     0
R cmd1_rd        11 0        64
R cmd4_rd        41 0        ffff
O cmd1_out       1  0        64
O cmd2_out       2  0        200
O cmd3_out       3  0        300
O cmd4_out       4  0        ffff
R unmapped_ch5   51 0        0
R unmapped_dev   13 0        0
F fb1_set        1  c8       0
F fb4_set        4  abcd     0
R fb1_rd         10 0        c8
R fb4_rd         40 0        abcd
W amp_en_all     01 f        0
O amp_on_all     0  0        0
F fb1_over3      1  c9       0
N run_of_3       0  2        0
F fb1_back       1  c8       0
R no_trip_status 00 0        f0f
F fb1_over4      1  c9       0
N run_of_4       0  3        0
F fb1_back2      1  c8       0
R trip_status    00 0        e1f
O amp_on_masked  0  1        0
W clear_ax1      01 1f       0
R clear_status   00 0        f0f
W amp_en_part    01 5        0
O amp_on_part    0  0        0
R part_status    00 0        505
W led_duties     02 80402001 0
R led_duty_rd    02 0        80402001
N led_latch      0  104      0
L led1_count     0  0        1
L led2_count     1  0        20
L led3_count     2  0        40
L led4_count     3  0        80

/* src.f */
rtl/qla_pkg.sv
rtl/cur_cmd_regs.sv
rtl/safety_check.sv
rtl/board_regs.sv
rtl/led_pwm.sv
rtl/qla_core.sv
bench/qla_core_tb.sv

/* Bender.yml */
package:
  name: qla_core

sources:
  - rtl/qla_pkg.sv
  - rtl/cur_cmd_regs.sv
  - rtl/safety_check.sv
  - rtl/board_regs.sv
  - rtl/led_pwm.sv
  - rtl/qla_core.sv
  - target: test
    files:
      - bench/qla_core_tb.sv

/* bench/qla_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module qla_core_tb import qla_pkg::*; ();

    logic      sysclk;
    logic      rst;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    logic      reg_wen;
    reg_data_t reg_rdata;
    cur_t      cur_fb1, cur_fb2, cur_fb3, cur_fb4;
    cur_t      cur_cmd1, cur_cmd2, cur_cmd3, cur_cmd4;
    axis_vec_t amp_on;
    axis_vec_t led;

    // parsed stimulus lines
    byte         op_q   [$];
    string       name_q [$];
    logic [31:0] arg_q  [$];  // address, axis, output select or led index
    logic [31:0] val_q  [$];
    logic [31:0] exp_q  [$];

    int        errors;
    int        checks;
    int        cycles = 0;
    int        cyc_limit = 0;  // 0 until the stimulus is loaded
    axis_vec_t model_en;       // enables as last written to control

    qla_core dut_i (.*);

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;  // 100 ns period
    end

    // watchdog ---------------------------------------------
    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cyc_limit != 0 && cycles >= cyc_limit) begin
            $display("timeout, stimulus still running after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        string       op;
        string       name;
        logic [31:0] a, v, e;
        fd = $fopen("bench/qla_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 3) continue;  // blank or last line
            if (line.getc(0) == "#") continue;        // column notes
            n = $sscanf(line, "%s %s %h %h %h", op, name, a, v, e);
            if (n != 5) begin
                $display("badly formed stimulus line: %s", line);
                errors++;
            end else begin
                op_q.push_back(op.getc(0));
                name_q.push_back(name);
                arg_q.push_back(a);
                val_q.push_back(v);
                exp_q.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // waits plus led counts, with 10 periods of slack
    function automatic int run_budget();
        int sum;
        sum = 10 * PWM_PERIOD;
        foreach (op_q[i]) begin
            if (op_q[i] == "N") sum += int'(val_q[i]);
            if (op_q[i] == "L") sum += PWM_PERIOD;
        end
        return sum;
    endfunction

    // high samples of one led over a full pwm period
    task automatic count_led(input string name, input int idx, input logic [31:0] exp);
        int high;
        high = 0;
        repeat (PWM_PERIOD) begin
            @(negedge sysclk);
            #25;
            if (led[idx]) high++;
        end
        check_value(name, exp, 32'(high));
    endtask

    task automatic run_op(input int i);
        case (op_q[i])
            "W": begin  // one cycle write strobe
                @(negedge sysclk);
                reg_addr  = reg_addr_t'(arg_q[i]);
                reg_wdata = val_q[i];
                reg_wen   = 1'b1;
                if (arg_q[i] == 32'({CHAN_BRD, BRD_CTRL})) model_en = val_q[i][3:0];
                @(negedge sysclk);
                reg_wen = 1'b0;
            end
            "F": begin
                @(negedge sysclk);
                case (arg_q[i])
                    1: cur_fb1 = cur_t'(val_q[i]);
                    2: cur_fb2 = cur_t'(val_q[i]);
                    3: cur_fb3 = cur_t'(val_q[i]);
                    4: cur_fb4 = cur_t'(val_q[i]);
                    default: begin
                        $display("feedback line %s names no axis", name_q[i]);
                        errors++;
                    end
                endcase
            end
            "R": begin
                @(negedge sysclk);
                reg_addr = reg_addr_t'(arg_q[i]);
                #25;  // mid low phase, rdata settled
                check_value(name_q[i], exp_q[i], reg_rdata);
            end
            "N": repeat (int'(val_q[i])) @(negedge sysclk);
            "O": begin
                @(negedge sysclk);
                #25;
                case (arg_q[i])
                    // value column holds the disables expected to be latched
                    0: check_value(name_q[i], 32'(model_en & ~axis_vec_t'(val_q[i])),
                                   32'(amp_on));
                    1: check_value(name_q[i], exp_q[i], 32'(cur_cmd1));
                    2: check_value(name_q[i], exp_q[i], 32'(cur_cmd2));
                    3: check_value(name_q[i], exp_q[i], 32'(cur_cmd3));
                    4: check_value(name_q[i], exp_q[i], 32'(cur_cmd4));
                    5: check_value(name_q[i], exp_q[i], 32'(led));
                    default: begin
                        $display("output line %s selects no output", name_q[i]);
                        errors++;
                    end
                endcase
            end
            "L": count_led(name_q[i], int'(arg_q[i][1:0]), exp_q[i]);
            default: begin
                $display("unknown op on stimulus line %s", name_q[i]);
                errors++;
            end
        endcase
    endtask

    // main sequence ----------------------------------------
    initial begin
        rst       = 1'b1;
        reg_addr  = '0;
        reg_wdata = '0;
        reg_wen   = 1'b0;
        cur_fb1   = '0;
        cur_fb2   = '0;
        cur_fb3   = '0;
        cur_fb4   = '0;
        model_en  = '0;
        errors    = 0;
        checks    = 0;
        load_stimulus();
        cyc_limit = run_budget();
        repeat (2) @(negedge sysclk);  // two reset edges
        rst = 1'b0;
        for (int i = 0; i < op_q.size(); i++) begin
            run_op(i);
        end
        @(negedge sysclk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/qla_core.sv */
`timescale 1ns/1ns
`default_nettype none

module qla_core import qla_pkg::*; (
    input  logic      sysclk,
    input  logic      rst,
    // host register bus
    input  reg_addr_t reg_addr,
    input  reg_data_t reg_wdata,
    input  logic      reg_wen,     // single cycle write strobe
    output reg_data_t reg_rdata,   // combinational from reg_addr
    // per axis currents
    input  cur_t      cur_fb1,
    input  cur_t      cur_fb2,
    input  cur_t      cur_fb3,
    input  cur_t      cur_fb4,
    output cur_t      cur_cmd1,
    output cur_t      cur_cmd2,
    output cur_t      cur_cmd3,
    output cur_t      cur_cmd4,
    // board outputs
    output axis_vec_t amp_on,
    output axis_vec_t led
);

    logic [3:0] chan;      // reg_addr[7:4]
    logic [3:0] dev;       // reg_addr[3:0]
    logic       axis_sel;  // channels 1..4
    logic [1:0] cmd_axis;
    logic       cmd_wen;
    logic       brd_wen;
    reg_data_t  cmd_rdata;
    reg_data_t  brd_rdata;
    cur_t       cur_fb_a  [NUM_AXES];
    cur_t       cur_cmd_a [NUM_AXES];
    axis_vec_t  safety_disable;
    axis_vec_t  safety_clear;
    axis_vec_t  amp_enable;
    duty_t      duty1, duty2, duty3, duty4;

    // address decode -----------------------------------------------
    assign chan     = reg_addr[7:4];
    assign dev      = reg_addr[3:0];
    assign axis_sel = (chan != CHAN_BRD) && (chan <= 4'(NUM_AXES));
    assign cmd_axis = 2'(chan - 4'd1);  // channel 1 is axis index 0
    assign cmd_wen  = reg_wen && axis_sel && (dev == DEV_CUR_CMD);
    assign brd_wen  = reg_wen && (chan == CHAN_BRD);

    assign cur_fb_a[0] = cur_fb1;
    assign cur_fb_a[1] = cur_fb2;
    assign cur_fb_a[2] = cur_fb3;
    assign cur_fb_a[3] = cur_fb4;

    // route read data by channel, then device
    always_comb begin
        reg_rdata = '0;  // unmapped reads as zero
        if (chan == CHAN_BRD) begin
            reg_rdata = brd_rdata;
        end else if (axis_sel) begin
            if (dev == DEV_CUR_FB) begin
                reg_rdata = {{(DATA_W-CUR_W){1'b0}}, cur_fb_a[cmd_axis]};
            end else if (dev == DEV_CUR_CMD) begin
                reg_rdata = cmd_rdata;
            end
        end
    end

    // command set points -------------------------------------------
    cur_cmd_regs cmd_regs_i (
        .sysclk    (sysclk),
        .rst       (rst),
        .cmd_wen   (cmd_wen),
        .cmd_axis  (cmd_axis),
        .reg_wdata (reg_wdata),
        .cmd1      (cur_cmd1),
        .cmd2      (cur_cmd2),
        .cmd3      (cur_cmd3),
        .cmd4      (cur_cmd4),
        .cmd_rdata (cmd_rdata)
    );

    assign cur_cmd_a[0] = cur_cmd1;
    assign cur_cmd_a[1] = cur_cmd2;
    assign cur_cmd_a[2] = cur_cmd3;
    assign cur_cmd_a[3] = cur_cmd4;

    // one over-current check per axis
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_safe
        safety_check safe_i (
            .sysclk      (sysclk),
            .rst         (rst),
            .cur_fb      (cur_fb_a[i]),
            .cur_cmd     (cur_cmd_a[i]),
            .clear       (safety_clear[i]),
            .amp_disable (safety_disable[i])
        );
    end

    // channel 0 board registers ------------------------------------
    board_regs chan0_i (
        .sysclk         (sysclk),
        .rst            (rst),
        .brd_wen        (brd_wen),
        .brd_dev        (dev),
        .reg_wdata      (reg_wdata),
        .safety_disable (safety_disable),
        .brd_rdata      (brd_rdata),
        .amp_enable     (amp_enable),
        .safety_clear   (safety_clear),
        .duty1          (duty1),
        .duty2          (duty2),
        .duty3          (duty3),
        .duty4          (duty4)
    );

    assign amp_on = amp_enable & ~safety_disable;  // trip overrides host enable

    led_pwm pwm_i (
        .sysclk (sysclk),
        .rst    (rst),
        .duty1  (duty1),
        .duty2  (duty2),
        .duty3  (duty3),
        .duty4  (duty4),
        .led    (led)
    );

endmodule

`default_nettype wire

/* rtl/led_pwm.sv */
`timescale 1ns/1ns
`default_nettype none

module led_pwm import qla_pkg::*; (
    input  logic      sysclk,
    input  logic      rst,
    input  duty_t     duty1,
    input  duty_t     duty2,
    input  duty_t     duty3,
    input  duty_t     duty4,
    output axis_vec_t led
);

    logic [PWM_CNT_W-1:0] pwm_cnt;  // shared period counter
    logic                 last_cnt;
    duty_t                duty_in [NUM_AXES];
    duty_t                duty_q  [NUM_AXES];  // held for a whole period

    assign duty_in[0] = duty1;
    assign duty_in[1] = duty2;
    assign duty_in[2] = duty3;
    assign duty_in[3] = duty4;

    assign last_cnt = (pwm_cnt == PWM_CNT_W'(PWM_PERIOD - 1));

    // period counter and duty latch --------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            pwm_cnt <= '0;
            for (int i = 0; i < NUM_AXES; i++) begin
                duty_q[i] <= '0;
            end
        end else begin
            pwm_cnt <= last_cnt ? '0 : pwm_cnt + 1'b1;
            if (last_cnt) begin
                duty_q <= duty_in;  // new duty applies from count 0
            end
        end
    end

    // registered outputs, high while below duty
    always_ff @(posedge sysclk) begin
        if (rst) begin
            led <= '0;
        end else begin
            for (int i = 0; i < NUM_AXES; i++) begin
                led[i] <= (PWM_CNT_W'(duty_q[i]) > pwm_cnt);
            end
        end
    end

    a_cnt_range: assert property (
        @(posedge sysclk) disable iff (rst)
        pwm_cnt <= PWM_CNT_W'(PWM_PERIOD - 1)
    ) else $error("led_pwm: period counter out of range");

endmodule

`default_nettype wire

/* rtl/board_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module board_regs import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst,
    input  logic       brd_wen,         // channel 0 write strobe
    input  logic [3:0] brd_dev,         // device offset within channel 0
    input  reg_data_t  reg_wdata,
    input  axis_vec_t  safety_disable,  // latched trips, axis 1 in bit 0
    output reg_data_t  brd_rdata,
    output axis_vec_t  amp_enable,
    output axis_vec_t  safety_clear,    // one cycle per write
    output duty_t      duty1,
    output duty_t      duty2,
    output duty_t      duty3,
    output duty_t      duty4
);

    axis_vec_t amp_on_loc;  // what the amps actually see

    assign amp_on_loc = amp_enable & ~safety_disable;

    // control register ---------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_enable   <= '0;
            safety_clear <= '0;
        end else begin
            safety_clear <= '0;  // default back to idle
            if (brd_wen && brd_dev == BRD_CTRL) begin
                amp_enable   <= reg_wdata[3:0];
                safety_clear <= reg_wdata[7:4];  // write 1 to release
            end
        end
    end

    // led duty register --------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            duty1 <= '0;
            duty2 <= '0;
            duty3 <= '0;
            duty4 <= '0;
        end else if (brd_wen && brd_dev == BRD_LED) begin
            duty1 <= reg_wdata[7:0];    // led 1 in low byte
            duty2 <= reg_wdata[15:8];
            duty3 <= reg_wdata[23:16];
            duty4 <= reg_wdata[31:24];
        end
    end

    // read mux -----------------------------------------------------
    always_comb begin
        case (brd_dev)
            BRD_STATUS: brd_rdata = {20'h0, amp_on_loc, safety_disable, amp_enable};
            BRD_CTRL:   brd_rdata = {28'h0, amp_enable};  // clear bits read zero
            BRD_LED:    brd_rdata = {duty4, duty3, duty2, duty1};
            default:    brd_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/safety_check.sv */
`timescale 1ns/1ns
`default_nettype none

module safety_check import qla_pkg::*; (
    input  logic sysclk,
    input  logic rst,
    input  cur_t cur_fb,       // measured current
    input  cur_t cur_cmd,      // commanded current
    input  logic clear,        // one cycle release pulse
    output logic amp_disable
);

    logic [SAFE_CNT_W-1:0] run_cnt;  // consecutive over-current samples
    logic                  over;

    // 17 bit compare so 2*cmd never wraps
    assign over = {1'b0, cur_fb} > {cur_cmd, 1'b0};

    // run counter and disable latch --------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            run_cnt     <= '0;
            amp_disable <= 1'b0;
        end else if (clear) begin
            run_cnt     <= '0;  // start a fresh run
            amp_disable <= 1'b0;
        end else begin
            if (!over) begin
                run_cnt <= '0;  // one good sample breaks the run
            end else if (run_cnt != SAFE_CNT_W'(SAFETY_CYCLES)) begin
                run_cnt <= run_cnt + 1'b1;  // saturate at the limit
            end

            // trips on the edge of the last sample of the run
            if (over && run_cnt == SAFE_CNT_W'(SAFETY_CYCLES - 1)) begin
                amp_disable <= 1'b1;
            end
        end
    end

    // a trip always leaves the counter at its limit
    a_trip_needs_run: assert property (
        @(posedge sysclk) disable iff (rst)
        $rose(amp_disable) |-> run_cnt == SAFE_CNT_W'(SAFETY_CYCLES)
    ) else $error("safety_check: disable rose without a full over-current run");

endmodule

`default_nettype wire

/* rtl/cur_cmd_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module cur_cmd_regs import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst,
    input  logic       cmd_wen,    // already qualified by address
    input  logic [1:0] cmd_axis,   // 0 = axis 1
    input  reg_data_t  reg_wdata,
    output cur_t       cmd1,
    output cur_t       cmd2,
    output cur_t       cmd3,
    output cur_t       cmd4,
    output reg_data_t  cmd_rdata
);

    cur_t cmd_q [NUM_AXES];  // dac set points

    // set point registers ------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                cmd_q[i] <= '0;
            end
        end else if (cmd_wen) begin
            cmd_q[cmd_axis] <= reg_wdata[CUR_W-1:0];  // low half only
        end
    end

    assign cmd1 = cmd_q[0];
    assign cmd2 = cmd_q[1];
    assign cmd3 = cmd_q[2];
    assign cmd4 = cmd_q[3];

    // read-back, zero extended
    assign cmd_rdata = {{(DATA_W-CUR_W){1'b0}}, cmd_q[cmd_axis]};

    // axis index comes from the top level address decode
    a_axis_known: assert property (
        @(posedge sysclk) disable iff (rst)
        cmd_wen |-> !$isunknown(cmd_axis)
    ) else $error("cur_cmd_regs: write with unknown axis index");

endmodule

`default_nettype wire

/* rtl/qla_pkg.sv */
`default_nettype none

package qla_pkg;

    // bus and datapath widths --------------------------------------
    localparam int ADDR_W   = 8;
    localparam int DATA_W   = 32;
    localparam int CUR_W    = 16;
    localparam int DUTY_W   = 8;
    localparam int NUM_AXES = 4;

    typedef logic [ADDR_W-1:0]   reg_addr_t;  // [7:4] channel, [3:0] device
    typedef logic [DATA_W-1:0]   reg_data_t;
    typedef logic [CUR_W-1:0]    cur_t;       // unsigned current magnitude
    typedef logic [NUM_AXES-1:0] axis_vec_t;  // axis 1 in bit 0
    typedef logic [DUTY_W-1:0]   duty_t;

    // register map -------------------------------------------------
    localparam logic [3:0] CHAN_BRD    = 4'd0;  // board register channel
    localparam logic [3:0] DEV_CUR_FB  = 4'd0;  // per axis feedback, read only
    localparam logic [3:0] DEV_CUR_CMD = 4'd1;  // per axis command, r/w

    // channel 0 devices
    localparam logic [3:0] BRD_STATUS = 4'd0;
    localparam logic [3:0] BRD_CTRL   = 4'd1;
    localparam logic [3:0] BRD_LED    = 4'd2;

    // safety and pwm timing ----------------------------------------
    localparam int SAFETY_CYCLES = 4;  // consecutive over-current samples to trip
    localparam int SAFE_CNT_W    = $clog2(SAFETY_CYCLES + 1);
    localparam int PWM_PERIOD    = 256;
    localparam int PWM_CNT_W     = $clog2(PWM_PERIOD);

endpackage

`default_nettype wire
